//--- sad.f
logic/sad_pkg.sv
logic/input_buffer.sv
logic/mult_share.sv
logic/det_unit.sv
logic/q_proj.sv
logic/out_serializer.sv
logic/sad_top.sv
tests/sad_asserts.sv
tests/sad_tb.sv

//--- tests/sad_tb.sv
// testbench for sad_top: stimulus table, reference model for det and Q,
// output window checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module sad_tb;

    localparam int     NUM_CASES   = 7;
    localparam int     WAIT_LIMIT  = 200;
    localparam longint WATCHDOG_NS = (NUM_CASES * (64 + 65 + 200) + 20) * 20;

    logic                              clk;
    logic                              rst_n;
    logic                              in_valid;
    logic [3:0]                        T;
    logic signed [sad_pkg::MAT_W-1:0]  in_data1;
    logic signed [sad_pkg::DATA_W-1:0] in_data2;
    logic signed [sad_pkg::DATA_W-1:0] w_q;
    logic                              out_valid;
    logic signed [sad_pkg::OUT_W-1:0]  out_data;

    // stimulus table: name, T, matrix pattern, data pattern, expected T_eff
    string      case_name [NUM_CASES];
    logic [3:0] case_t    [NUM_CASES];
    int         case_mat  [NUM_CASES];
    int         case_data [NUM_CASES];
    int         case_teff [NUM_CASES];

    logic signed [sad_pkg::MAT_W-1:0]  mat_v [16];
    logic signed [sad_pkg::DATA_W-1:0] act_v [64];
    logic signed [sad_pkg::DATA_W-1:0] wq_v  [64];
    longint                            exp_det;
    longint                            exp_q [64];
    int unsigned                       seed;

    sad_top sad_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .T         (T),
        .in_data1  (in_data1),
        .in_data2  (in_data2),
        .w_q       (w_q),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: run timed out after %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input longint exp_v, input longint act_v);
        if (exp_v !== act_v) begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp_v, act_v);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_case(input int n, input string name, input logic [3:0] t,
                            input int m_sel, input int d_sel, input int teff);
        case_name[n] = name;
        case_t[n]    = t;
        case_mat[n]  = m_sel;
        case_data[n] = d_sel;
        case_teff[n] = teff;
    endtask

    // matrix 0 identity, 1 singular, 2 diagonal -32, else random
    // data 1 mixed extremes, 2 all -128, else random
    task automatic build_operands(input int m_sel, input int d_sel);
        for (int i = 0; i < 16; i++) begin
            case (m_sel)
                0:       mat_v[i] = (i % 5 == 0) ? 6'sd1 : 6'sd0;
                2:       mat_v[i] = (i % 5 == 0) ? -6'sd32 : 6'sd0;
                default: mat_v[i] = 6'($urandom);
            endcase
        end
        if (m_sel == 1) begin
            // row 3 repeats row 1
            for (int j = 0; j < 4; j++) begin
                mat_v[12 + j] = mat_v[4 + j];
            end
        end
        for (int i = 0; i < 64; i++) begin
            case (d_sel)
                1: begin
                    act_v[i] = ($urandom & 1) ? 8'sh80 : 8'sh7f;
                    wq_v[i]  = ($urandom & 1) ? 8'sh80 : 8'sh7f;
                end
                2: begin
                    act_v[i] = 8'sh80;
                    wq_v[i]  = 8'sh80;
                end
                default: begin
                    act_v[i] = 8'($urandom);
                    wq_v[i]  = 8'($urandom);
                end
            endcase
        end
    endtask

    // ##################################################
    // reference model
    function automatic longint mat_at(input int r, input int c);
        return longint'(mat_v[r * 4 + c]);
    endfunction

    // 3x3 determinant of rows 1..3 without column skip
    function automatic longint det3_without(input int skip);
        int cols [3];
        int n;
        n = 0;
        for (int j = 0; j < 4; j++) begin
            if (j != skip) begin
                cols[n] = j;
                n++;
            end
        end
        return mat_at(1, cols[0]) * (mat_at(2, cols[1]) * mat_at(3, cols[2])
                                     - mat_at(2, cols[2]) * mat_at(3, cols[1]))
             - mat_at(1, cols[1]) * (mat_at(2, cols[0]) * mat_at(3, cols[2])
                                     - mat_at(2, cols[2]) * mat_at(3, cols[0]))
             + mat_at(1, cols[2]) * (mat_at(2, cols[0]) * mat_at(3, cols[1])
                                     - mat_at(2, cols[1]) * mat_at(3, cols[0]));
    endfunction

    task automatic compute_expected(input int teff);
        longint acc;
        exp_det = 0;
        for (int c = 0; c < 4; c++) begin
            if (c % 2 == 0) begin
                exp_det = exp_det + mat_at(0, c) * det3_without(c);
            end else begin
                exp_det = exp_det - mat_at(0, c) * det3_without(c);
            end
        end
        for (int e = 0; e < 8 * teff; e++) begin
            acc = 0;
            for (int k = 0; k < 8; k++) begin
                acc = acc + longint'(act_v[(e / 8) * 8 + k]) * longint'(wq_v[k * 8 + e % 8]);
            end
            exp_q[e] = acc;
        end
    endtask

    // ##################################################
    // stimulus and output checks
    task automatic drive_burst(input int n);
        for (int i = 0; i < sad_pkg::LOAD_CYCLES; i++) begin
            @(posedge clk);
            #2;
            in_valid = 1'b1;
            // beats outside each stream's window carry junk
            T        = (i == 0) ? case_t[n] : 4'($urandom);
            in_data1 = (i < 16) ? mat_v[i] : 6'($urandom);
            in_data2 = (i < 8 * case_teff[n]) ? act_v[i] : 8'($urandom);
            w_q      = wq_v[i];
            @(negedge clk);
            check_value({case_name[n], " valid during load"}, 0, out_valid);
            check_value({case_name[n], " data during load"}, 0, out_data);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        T        = '0;
        in_data1 = '0;
        in_data2 = '0;
        w_q      = '0;
    endtask

    task automatic check_stream(input int n);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!out_valid) begin
            check_value({case_name[n], " data before window"}, 0, out_data);
            if (waited == WAIT_LIMIT) begin
                $display("ERROR: %s: out_valid did not rise within %0d cycles",
                         case_name[n], WAIT_LIMIT);
                $display("TESTS FAILED");
                $fatal(1, "no output window");
            end
            waited++;
            @(negedge clk);
        end
        check_value({case_name[n], " determinant"}, exp_det, out_data);
        for (int j = 0; j < 8 * case_teff[n]; j++) begin
            @(negedge clk);
            check_value($sformatf("%s valid word %0d", case_name[n], j + 1), 1, out_valid);
            check_value($sformatf("%s q[%0d]", case_name[n], j), exp_q[j], out_data);
        end
        @(negedge clk);
        check_value({case_name[n], " valid after window"}, 0, out_valid);
        check_value({case_name[n], " data after window"}, 0, out_data);
    endtask

    initial begin
        seed = 32'h8a72;
        void'($urandom(seed));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        T        = '0;
        in_data1 = '0;
        in_data2 = '0;
        w_q      = '0;
        add_case(0, "identity_t1", 4'd1, 0, 0, 1);
        add_case(1, "singular_t4", 4'd4, 1, 1, 4);
        add_case(2, "neg_diag_t8", 4'd8, 2, 2, 8);
        add_case(3, "random_t3",   4'd3, 3, 0, 8);
        add_case(4, "random_t1",   4'd1, 3, 1, 1);
        add_case(5, "random_t0",   4'd0, 3, 0, 8);
        add_case(6, "random_t4",   4'd4, 3, 2, 4);
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("after reset valid", 0, out_valid);
            check_value("after reset data", 0, out_data);
        end
        // bursts run back to back, each right after the previous window
        for (int n = 0; n < NUM_CASES; n++) begin
            build_operands(case_mat[n], case_data[n]);
            compute_expected(case_teff[n]);
            drive_burst(n);
            check_stream(n);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/sad_asserts.sv
// concurrent checks on arbitration and the output stream, bound to sad_top
`timescale 1ns/1ps
`default_nettype none

module sad_asserts (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              in_valid,
    input logic                              out_valid,
    input logic signed [sad_pkg::OUT_W-1:0]  out_data,
    input sad_pkg::mult_req_t                det_req,
    input sad_pkg::mult_req_t                q_req,
    input sad_pkg::mult_rsp_t                rsp
);

    // one owner per slot, the determinant wins a tie
    det_served_first: assert property (@(posedge clk) disable iff (!rst_n)
        det_req.valid |=> (rsp.valid && rsp.owner == sad_pkg::OWN_DET))
        else $error("determinant request not served in the next cycle");

    q_served_alone: assert property (@(posedge clk) disable iff (!rst_n)
        (q_req.valid && !det_req.valid) |=> (rsp.valid && rsp.owner == sad_pkg::OWN_QPROJ))
        else $error("lone Q request not served in the next cycle");

    no_request_no_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        (!det_req.valid && !q_req.valid) |=> !rsp.valid)
        else $error("multiplier response without a request");

    // ##################################################
    // output stream
    out_zero_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_data == '0))
        else $error("out_data not zero while out_valid is low");

    no_out_during_load: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid && in_valid))
        else $error("out_valid high during an input burst");

endmodule

bind sad_top sad_asserts sad_asserts_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_data  (out_data),
    .det_req   (det_req),
    .q_req     (q_req),
    .rsp       (rsp)
);

`default_nettype wire

//--- logic/sad_top.sv
// top level: input capture, determinant and Q units around one shared
// multiplier array, and the output stream
`timescale 1ns/1ps
`default_nettype none

module sad_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  logic [3:0]                        T,
    input  logic signed [sad_pkg::MAT_W-1:0]  in_data1,
    input  logic signed [sad_pkg::DATA_W-1:0] in_data2,
    input  logic signed [sad_pkg::DATA_W-1:0] w_q,
    output logic                              out_valid,
    output logic signed [sad_pkg::OUT_W-1:0]  out_data
);

    sad_pkg::load_bus_t               load;
    logic                             load_done;
    sad_pkg::mult_req_t               det_req;
    sad_pkg::mult_req_t               q_req;
    sad_pkg::mult_rsp_t               rsp;
    logic                             det_done;
    logic                             q_done;
    logic                             run_clear;
    logic signed [sad_pkg::DET_W-1:0] det_value;
    logic signed [sad_pkg::Q_W-1:0]   q_rd_data;
    logic [5:0]                       rd_index;

    input_buffer input_buffer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .T         (T),
        .in_data1  (in_data1),
        .in_data2  (in_data2),
        .w_q       (w_q),
        .load      (load),
        .load_done (load_done)
    );

    mult_share mult_share_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .det_req (det_req),
        .q_req   (q_req),
        .rsp     (rsp)
    );

    det_unit det_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_done (load_done),
        .run_clear (run_clear),
        .load      (load),
        .rsp       (rsp),
        .req       (det_req),
        .det_done  (det_done),
        .det_value (det_value)
    );

    q_proj q_proj_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_done (load_done),
        .run_clear (run_clear),
        .load      (load),
        .rsp       (rsp),
        .rd_index  (rd_index),
        .req       (q_req),
        .q_done    (q_done),
        .rd_data   (q_rd_data)
    );

    out_serializer out_serializer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .det_done  (det_done),
        .q_done    (q_done),
        .det_value (det_value),
        .q_rd_data (q_rd_data),
        .load      (load),
        .rd_index  (rd_index),
        .run_clear (run_clear),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- logic/out_serializer.sv
// result stream: determinant word, then the Q entries in row-major order
`timescale 1ns/1ps
`default_nettype none

module out_serializer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              det_done,
    input  logic                              q_done,
    input  logic signed [sad_pkg::DET_W-1:0]  det_value,
    input  logic signed [sad_pkg::Q_W-1:0]    q_rd_data,
    input  sad_pkg::load_bus_t                load,
    output logic [5:0]                        rd_index,
    output logic                              run_clear,
    output logic                              out_valid,
    output logic signed [sad_pkg::OUT_W-1:0]  out_data
);

    sad_pkg::out_state_t state;
    logic [5:0]          idx;
    logic [6:0]          n_ent;
    logic                last;

    always_comb begin
        n_ent     = {load.t_eff, 3'b000};
        last      = (state == sad_pkg::OUT_Q) && ({1'b0, idx} == n_ent - 7'd1);
        rd_index  = idx;
        out_valid = (state != sad_pkg::OUT_IDLE);
        case (state)
            sad_pkg::OUT_DET: out_data = sad_pkg::OUT_W'(det_value);
            sad_pkg::OUT_Q:   out_data = sad_pkg::OUT_W'(q_rd_data);
            default:          out_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sad_pkg::OUT_IDLE;
            idx       <= '0;
            run_clear <= 1'b0;
        end else begin
            run_clear <= last;
            case (state)
                sad_pkg::OUT_IDLE: begin
                    // done levels are still high during the run_clear cycle
                    if (det_done && q_done && !run_clear) begin
                        state <= sad_pkg::OUT_DET;
                    end
                end
                sad_pkg::OUT_DET: begin
                    state <= sad_pkg::OUT_Q;
                    idx   <= '0;
                end
                default: begin
                    idx <= idx + 6'd1;
                    if (last) begin
                        state <= sad_pkg::OUT_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/q_proj.sv
// Q projection sequencer, one activation row against one weight column per grant
// and the 64-entry Q result buffer
`timescale 1ns/1ps
`default_nettype none

module q_proj (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load_done,
    input  logic                            run_clear,
    input  sad_pkg::load_bus_t              load,
    input  sad_pkg::mult_rsp_t              rsp,
    input  logic [5:0]                      rd_index,
    output sad_pkg::mult_req_t              req,
    output logic                            q_done,
    output logic signed [sad_pkg::Q_W-1:0]  rd_data
);

    logic                           busy;
    logic                           own;
    logic [6:0]                     prev_idx;
    logic [6:0]                     req_idx;
    logic [6:0]                     n_ent;
    logic signed [sad_pkg::Q_W-1:0] sum;
    logic signed [sad_pkg::Q_W-1:0] q_buf [64];

    // an own response means last cycle's entry was granted, so move on at once
    always_comb begin
        own       = rsp.valid && (rsp.owner == sad_pkg::OWN_QPROJ);
        n_ent     = {load.t_eff, 3'b000};
        req_idx   = prev_idx + {6'd0, own};
        req.valid = busy && (req_idx < n_ent);
        for (int l = 0; l < sad_pkg::LANES; l++) begin
            req.a[l] = load.act[req_idx[5:3] * sad_pkg::D_MODEL + l];
            req.b[l] = load.wq[l * sad_pkg::D_MODEL + req_idx[2:0]];
        end
    end

    // dot product of the returning entry
    always_comb begin
        sad_pkg::prod_t p;
        sum = '0;
        for (int l = 0; l < sad_pkg::LANES; l++) begin
            p   = rsp.prod[l];
            sum = sum + sad_pkg::Q_W'(p);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            prev_idx <= '0;
            q_done   <= 1'b0;
        end else begin
            if (load_done) begin
                busy     <= 1'b1;
                prev_idx <= '0;
            end else if (busy) begin
                prev_idx <= req_idx;
                if (own && prev_idx == n_ent - 7'd1) begin
                    busy   <= 1'b0;
                    q_done <= 1'b1;
                end
            end
            if (run_clear) begin
                q_done <= 1'b0;
            end
        end
    end

    // response belongs to the entry presented one cycle earlier
    always_ff @(posedge clk) begin
        if (own) begin
            q_buf[prev_idx[5:0]] <= sum;
        end
    end

    assign rd_data = q_buf[rd_index];

endmodule

`default_nettype wire

//--- logic/det_unit.sv
// 4x4 determinant by Laplace expansion over 2x2 minors of rows 0-1 and 2-3
// minor products come from the shared array, the combine step has its own multiplier
`timescale 1ns/1ps
`default_nettype none

module det_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              load_done,
    input  logic                              run_clear,
    input  sad_pkg::load_bus_t                load,
    input  sad_pkg::mult_rsp_t                rsp,
    output sad_pkg::mult_req_t                req,
    output logic                              det_done,
    output logic signed [sad_pkg::DET_W-1:0]  det_value
);

    typedef logic signed [12:0] minor_t;

    sad_pkg::det_state_t state;
    logic [1:0]          b_prev;
    logic [1:0]          b_req;
    logic [2:0]          k;
    logic                own;
    minor_t              top [6];
    minor_t              bot [6];
    logic signed [25:0]  cprod;

    // column pairs (0,1) (0,2) (0,3) (1,2) (1,3) (2,3), complement of p is 5-p
    function automatic logic [3:0] pair_cols(input logic [2:0] p);
        case (p)
            3'd0:    pair_cols = {2'd0, 2'd1};
            3'd1:    pair_cols = {2'd0, 2'd2};
            3'd2:    pair_cols = {2'd0, 2'd3};
            3'd3:    pair_cols = {2'd1, 2'd2};
            3'd4:    pair_cols = {2'd1, 2'd3};
            default: pair_cols = {2'd2, 2'd3};
        endcase
    endfunction

    function automatic sad_pkg::opnd_t entry(input logic [1:0] r, input logic [1:0] c);
        sad_pkg::mat_entry_t e;
        e = load.mat[r * sad_pkg::MAT_N + c];
        return {{(sad_pkg::DATA_W - sad_pkg::MAT_W){e[sad_pkg::MAT_W-1]}}, e};
    endfunction

    function automatic minor_t minor_of(input sad_pkg::prod_t pa, input sad_pkg::prod_t pb);
        sad_pkg::prod_t d;
        d = pa - pb;
        return d[12:0];
    endfunction

    // ##################################################
    // minor requests
    // a batch is 4 minors: top pair 2b, top 2b+1, bottom 2b, bottom 2b+1
    always_comb begin
        logic [2:0] p;
        logic [3:0] cols;
        logic [1:0] r;
        own       = rsp.valid && (rsp.owner == sad_pkg::OWN_DET);
        b_req     = b_prev + {1'b0, own};
        req.valid = (state == sad_pkg::DET_MINOR) && (b_req != 2'd3);
        for (int g = 0; g < 4; g++) begin
            p    = {b_req, g[0]};
            cols = pair_cols(p);
            r    = g[1] ? 2'd2 : 2'd0;
            req.a[2*g]   = entry(r, cols[3:2]);
            req.b[2*g]   = entry(r + 2'd1, cols[1:0]);
            req.a[2*g+1] = entry(r, cols[1:0]);
            req.b[2*g+1] = entry(r + 2'd1, cols[3:2]);
        end
    end

    always_ff @(posedge clk) begin
        if (own && state == sad_pkg::DET_MINOR) begin
            for (int g = 0; g < 4; g++) begin
                if (!g[1]) begin
                    top[{b_prev, g[0]}] <= minor_of(rsp.prod[2*g], rsp.prod[2*g+1]);
                end else begin
                    bot[{b_prev, g[0]}] <= minor_of(rsp.prod[2*g], rsp.prod[2*g+1]);
                end
            end
        end
    end

    // ##################################################
    // control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= sad_pkg::DET_IDLE;
            b_prev <= '0;
            k      <= '0;
        end else begin
            case (state)
                sad_pkg::DET_IDLE: begin
                    if (load_done) begin
                        state  <= sad_pkg::DET_MINOR;
                        b_prev <= '0;
                    end
                end
                sad_pkg::DET_MINOR: begin
                    b_prev <= b_req;
                    if (own && b_prev == 2'd2) begin
                        state <= sad_pkg::DET_COMBINE;
                        k     <= '0;
                    end
                end
                sad_pkg::DET_COMBINE: begin
                    if (k == 3'd5) begin
                        state <= sad_pkg::DET_DONE;
                    end else begin
                        k <= k + 3'd1;
                    end
                end
                default: begin
                    if (run_clear) begin
                        state <= sad_pkg::DET_IDLE;
                    end
                end
            endcase
        end
    end

    // ##################################################
    // combine, pairs 1 and 4 carry a minus sign
    assign cprod = top[k] * bot[3'd5 - k];

    always_ff @(posedge clk) begin
        if (state == sad_pkg::DET_MINOR) begin
            det_value <= '0;
        end else if (state == sad_pkg::DET_COMBINE) begin
            if (k == 3'd1 || k == 3'd4) begin
                det_value <= det_value - cprod[sad_pkg::DET_W-1:0];
            end else begin
                det_value <= det_value + cprod[sad_pkg::DET_W-1:0];
            end
        end
    end

    assign det_done = (state == sad_pkg::DET_DONE);

endmodule

`default_nettype wire

//--- logic/mult_share.sv
// fixed-priority arbiter and the shared eight-lane signed multiplier array
`timescale 1ns/1ps
`default_nettype none

module mult_share (
    input  logic               clk,
    input  logic               rst_n,
    input  sad_pkg::mult_req_t det_req,
    input  sad_pkg::mult_req_t q_req,
    output sad_pkg::mult_rsp_t rsp
);

    logic              grant_det;
    logic              any_req;
    logic              rsp_valid;
    sad_pkg::owner_t   rsp_owner;
    sad_pkg::lane_vec_t op_a;
    sad_pkg::lane_vec_t op_b;

    // determinant wins a tie
    always_comb begin
        grant_det = det_req.valid;
        any_req   = det_req.valid || q_req.valid;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_owner <= sad_pkg::OWN_DET;
        end else begin
            rsp_valid <= any_req;
            rsp_owner <= grant_det ? sad_pkg::OWN_DET : sad_pkg::OWN_QPROJ;
        end
    end

    // granted operands, held for the response cycle
    always_ff @(posedge clk) begin
        if (any_req) begin
            op_a <= grant_det ? det_req.a : q_req.a;
            op_b <= grant_det ? det_req.b : q_req.b;
        end
    end

    always_comb begin
        rsp.valid = rsp_valid;
        rsp.owner = rsp_owner;
        for (int l = 0; l < sad_pkg::LANES; l++) begin
            rsp.prod[l] = $signed(op_a[l]) * $signed(op_b[l]);
        end
    end

endmodule

`default_nettype wire

//--- logic/input_buffer.sv
// serial capture of T, the 4x4 matrix, the activation rows and the Q weights
`timescale 1ns/1ps
`default_nettype none

module input_buffer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  logic [3:0]                        T,
    input  logic signed [sad_pkg::MAT_W-1:0]  in_data1,
    input  logic signed [sad_pkg::DATA_W-1:0] in_data2,
    input  logic signed [sad_pkg::DATA_W-1:0] w_q,
    output sad_pkg::load_bus_t                load,
    output logic                              load_done
);

    logic [5:0] cnt;
    logic [3:0] t_eff_now;
    logic [6:0] act_limit;

    // T only counts on the first beat, later beats reuse the stored T_eff
    always_comb begin
        if (cnt == 6'd0) begin
            case (T)
                4'd1:    t_eff_now = 4'd1;
                4'd4:    t_eff_now = 4'd4;
                default: t_eff_now = 4'd8;
            endcase
        end else begin
            t_eff_now = load.t_eff;
        end
        act_limit = {t_eff_now, 3'b000};
    end

    // beat counter and end-of-burst pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= in_valid && (cnt == 6'(sad_pkg::LOAD_CYCLES - 1));
            if (in_valid) begin
                cnt <= cnt + 6'd1;
            end else begin
                cnt <= '0;
            end
        end
    end

    // each stream lands at the address given by the beat count
    always_ff @(posedge clk) begin
        if (in_valid) begin
            if (cnt == 6'd0) begin
                load.t_eff <= t_eff_now;
            end
            if (cnt < 6'(sad_pkg::MAT_N * sad_pkg::MAT_N)) begin
                load.mat[cnt[3:0]] <= in_data1;
            end
            if ({1'b0, cnt} < act_limit) begin
                load.act[cnt] <= in_data2;
            end
            load.wq[cnt] <= w_q;
        end
    end

endmodule

`default_nettype wire

//--- logic/sad_pkg.sv
// widths, states and owner tags shared by the accelerator units
// lane operand and product vectors, multiplier request and response buses
`default_nettype none

package sad_pkg;

    // ##################################################
    // sizes
    localparam int D_MODEL     = 8;
    localparam int MAT_N       = 4;
    localparam int MAT_W       = 6;
    localparam int DATA_W      = 8;
    localparam int PROD_W      = 16;
    localparam int Q_W         = 19;
    localparam int DET_W       = 25;
    localparam int OUT_W       = 25;
    localparam int LOAD_CYCLES = 64;
    localparam int LANES       = 8;

    // ##################################################
    // element and vector types
    typedef logic signed [MAT_W-1:0]  mat_entry_t;
    typedef logic signed [DATA_W-1:0] opnd_t;
    typedef logic signed [PROD_W-1:0] prod_t;

    typedef opnd_t [LANES-1:0] lane_vec_t;
    typedef prod_t [LANES-1:0] prod_vec_t;

    // requester that owns a multiplier slot
    typedef enum logic {
        OWN_DET   = 1'b0,
        OWN_QPROJ = 1'b1
    } owner_t;

    typedef struct packed {
        logic      valid;
        lane_vec_t a;
        lane_vec_t b;
    } mult_req_t;

    typedef struct packed {
        logic      valid;
        owner_t    owner;
        prod_vec_t prod;
    } mult_rsp_t;

    typedef enum logic [1:0] {
        DET_IDLE,
        DET_MINOR,
        DET_COMBINE,
        DET_DONE
    } det_state_t;

    typedef enum logic [1:0] {
        OUT_IDLE,
        OUT_DET,
        OUT_Q
    } out_state_t;

    // everything captured during one input burst
    typedef struct packed {
        logic [3:0]                            t_eff;
        mat_entry_t [MAT_N*MAT_N-1:0]          mat;
        opnd_t      [D_MODEL*D_MODEL-1:0]      act;
        opnd_t      [D_MODEL*D_MODEL-1:0]      wq;
    } load_bus_t;

endpackage

`default_nettype wire
